/* Bender.yml */
package:
  name: muldiv

sources:
  # packages first, the ISA one is used by the other
  - hdl/rv32m_pkg.sv
  - hdl/muldiv_pkg.sv
  # design
  - hdl/mul_issue.sv
  - hdl/op_fifo.sv
  - hdl/seq_multiplier.sv
  - hdl/muldiv_unit.sv
  # testbench, top module tb_muldiv
  - target: test
    files:
      - bench/muldiv_sva.sv
      - bench/tb_muldiv.sv

/* bench/muldiv_sva.sv */
module muldiv_sva (
    input logic clk,
    input logic rst,

    input muldiv_pkg::mul_req_t req,
    input logic                 req_valid,
    input logic                 req_ready,

    input muldiv_pkg::mul_result_t res,
    input logic                    res_valid,
    input logic                    res_ready
);

  int               fail_count = 0;  // read by the testbench
  muldiv_pkg::tag_t exp_tag;         // next tag expected at the result port
  logic             seen_req;

  always_ff @(posedge clk) begin
    if (rst) begin
      exp_tag  <= '0;
      seen_req <= 1'b0;
    end else begin
      if (res_valid && res_ready) begin
        exp_tag <= exp_tag + 1'b1;
      end
      if (req_valid && req_ready) begin
        seen_req <= 1'b1;
      end
    end
  end

  // stalled result stays put
  res_hold: assert property (@(posedge clk) disable iff (rst)
      res_valid && !res_ready |=> res_valid && $stable(res))
    else begin
      fail_count++;
      $error("result changed or was withdrawn while res_ready was low");
    end

  // offered request stays put until taken
  req_hold: assert property (@(posedge clk) disable iff (rst)
      req_valid && !req_ready |=> req_valid && $stable(req))
    else begin
      fail_count++;
      $error("request changed or was withdrawn before it was taken");
    end

  tag_order: assert property (@(posedge clk) disable iff (rst)
      res_valid && res_ready |-> res.tag == exp_tag)
    else begin
      fail_count++;
      $error("result tag out of issue order");
    end

  no_early_result: assert property (@(posedge clk) disable iff (rst)
      !seen_req |-> !res_valid)
    else begin
      fail_count++;
      $error("res_valid high before any request was accepted");
    end

endmodule : muldiv_sva

/* bench/tb_muldiv.sv */
module tb_muldiv;

  localparam int op_depth      = 4;
  localparam int res_depth     = 2;
  localparam int max_in_flight = op_depth + res_depth + 2;
  localparam int wait_limit    = 2000;  // cycles per wait loop

  logic                    clk = 1'b0;
  logic                    rst;
  muldiv_pkg::mul_req_t    req;
  logic                    req_valid;
  logic                    req_ready;
  muldiv_pkg::mul_result_t res;
  logic                    res_valid;
  logic                    res_ready;

  logic [15:0]             lfsr     = 16'd48;  // operands, variants, rd
  logic [15:0]             gap_lfsr = 16'd48;  // res_ready gaps
  muldiv_pkg::mul_result_t exp_q[$];
  string                   name_q[$];
  muldiv_pkg::mul_result_t pend_exp;           // expected result of the offered request
  string                   pend_name;
  muldiv_pkg::tag_t        next_tag     = '0;
  int                      errors       = 0;
  int                      sent         = 0;
  int                      received     = 0;
  bit                      hold_results = 1'b0;
  bit                      aborted      = 1'b0;

  logic [31:0] corner_a[6] = '{32'h8000_0000, 32'hFFFF_FFFF, 32'h8000_0000,
                               32'hFFFF_FFF9, 32'h7FFF_FFFF, 32'h0000_0005};
  logic [31:0] corner_b[6] = '{32'h8000_0000, 32'hFFFF_FFFF, 32'hFFFF_FFFF,
                               32'h0000_0003, 32'h7FFF_FFFF, 32'hFFFF_FFFA};
  string       variant_name[4] = '{"mul", "mulh", "mulhsu", "mulhu"};

  always #5 clk = ~clk;

  muldiv_unit #(
      .op_depth (op_depth),
      .res_depth(res_depth)
  ) UUT (
      .clk      (clk),
      .rst      (rst),
      .req      (req),
      .req_valid(req_valid),
      .req_ready(req_ready),
      .res      (res),
      .res_valid(res_valid),
      .res_ready(res_ready)
  );

  bind muldiv_unit muldiv_sva sva (
      .clk      (clk),
      .rst      (rst),
      .req      (req),
      .req_valid(req_valid),
      .req_ready(req_ready),
      .res      (res),
      .res_valid(res_valid),
      .res_ready(res_ready)
  );

  // galois form with taps for x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  task automatic take_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      v    = {v[30:0], lfsr[0]};
      lfsr = lfsr_next(lfsr);
    end
  endtask

  function automatic logic gap_bit();
    logic b;
    b        = gap_lfsr[0];
    gap_lfsr = lfsr_next(gap_lfsr);
    return b;
  endfunction

  // full 64-bit product of the extended operands
  function automatic logic [31:0] expected_value(input rv32m_pkg::mul_funct3_t f,
                                                 input logic [31:0] a, input logic [31:0] b);
    logic [63:0] wa;
    logic [63:0] wb;
    logic [63:0] prod;
    wa   = (f == rv32m_pkg::funct3_mulhu) ? {32'b0, a} : {{32{a[31]}}, a};
    wb   = (f == rv32m_pkg::funct3_mul || f == rv32m_pkg::funct3_mulh) ?
           {{32{b[31]}}, b} : {32'b0, b};
    prod = wa * wb;
    return (f == rv32m_pkg::funct3_mul) ? prod[31:0] : prod[63:32];
  endfunction

  task automatic give_up(input string what);
    $display("timeout: %s", what);
    errors++;
    aborted = 1'b1;
  endtask

  // sample ready mid-cycle, then land just after the edge
  task automatic step_cycle(output logic ready_seen);
    @(negedge clk);
    ready_seen = req_ready;
    @(posedge clk);
    #1;
  endtask

  task automatic load_req(input string name, input rv32m_pkg::mul_funct3_t f,
                          input logic [31:0] a, input logic [31:0] b);
    logic [31:0] rd_bits;
    take_bits(5, rd_bits);
    req.tag        = next_tag;
    req.rd         = rd_bits[4:0];
    req.funct3     = f;
    req.rs1        = a;
    req.rs2        = b;
    pend_exp.tag   = next_tag;
    pend_exp.rd    = rd_bits[4:0];
    pend_exp.value = expected_value(f, a, b);
    pend_name      = name;
    req_valid      = 1'b1;
  endtask

  task automatic load_random(input string name);
    logic [31:0] f;
    logic [31:0] a;
    logic [31:0] b;
    take_bits(2, f);
    take_bits(32, a);
    take_bits(32, b);
    load_req(name, rv32m_pkg::mul_funct3_t'({1'b0, f[1:0]}), a, b);
  endtask

  task automatic record_accept();
    exp_q.push_back(pend_exp);
    name_q.push_back(pend_name);
    next_tag++;
    sent++;
  endtask

  // offered request stays on the port until taken
  task automatic wait_accept();
    logic taken;
    int   cycles;
    taken  = 1'b0;
    cycles = 0;
    while (!taken && !aborted) begin
      step_cycle(taken);
      cycles++;
      if (!taken && cycles >= wait_limit) give_up("request was never accepted");
    end
    if (taken) record_accept();
    req_valid = 1'b0;
  endtask

  task automatic send(input string name, input rv32m_pkg::mul_funct3_t f,
                      input logic [31:0] a, input logic [31:0] b);
    if (aborted) return;
    load_req(name, f, a, b);
    wait_accept();
  endtask

  task automatic send_random(input string name);
    if (aborted) return;
    load_random(name);
    wait_accept();
  endtask

  // count checked mid-cycle, returns just after an edge
  task automatic drain();
    int cycles;
    cycles = 0;
    while (received != sent && !aborted) begin
      @(negedge clk);
      cycles++;
      if (cycles >= wait_limit) give_up("not all results came back");
    end
    @(posedge clk);
    #1;
  endtask

  // res_ready held low until req_ready stays low well past one multiply
  task automatic stall_test();
    logic ready_seen;
    int   accepted;
    int   low_run;
    int   cycles;
    if (aborted) return;
    accepted     = 0;
    low_run      = 0;
    cycles       = 0;
    hold_results = 1'b1;
    load_random("stall_fill");
    while (low_run < 80 && !aborted) begin
      step_cycle(ready_seen);
      cycles++;
      if (ready_seen) begin
        record_accept();
        accepted++;
        low_run = 0;
        load_random("stall_fill");
      end else begin
        low_run++;
      end
      if (low_run < 80 && cycles >= wait_limit) give_up("req_ready never dropped");
    end
    assert (aborted || accepted == max_in_flight) else begin
      errors++;
      $display("FAIL stall_depth: expected %0d, actual %0d", max_in_flight, accepted);
    end
    hold_results = 1'b0;
    wait_accept();  // the blocked request goes in once results flow
  endtask

  task automatic check_result(input muldiv_pkg::mul_result_t got);
    muldiv_pkg::mul_result_t exp;
    string                   name;
    received++;
    if (exp_q.size() == 0) begin
      errors++;
      $display("result with tag %0d arrived with no request outstanding", got.tag);
      return;
    end
    exp  = exp_q.pop_front();
    name = name_q.pop_front();
    assert (got.value == exp.value) else begin
      errors++;
      $display("FAIL %s: expected %h, actual %h", name, exp.value, got.value);
    end
    assert (got.tag == exp.tag && got.rd == exp.rd) else begin
      errors++;
      $display("FAIL %s tag/rd: expected %0d/%0d, actual %0d/%0d",
               name, exp.tag, exp.rd, got.tag, got.rd);
    end
  endtask

  // result port consumer
  initial begin : consume
    muldiv_pkg::mul_result_t got;
    logic                    took;
    logic                    next_ready;
    res_ready = 1'b0;
    forever begin
      @(negedge clk);
      took       = !rst && res_valid && res_ready;
      got        = res;
      next_ready = !hold_results && !(gap_bit() & gap_bit());  // about one gap in four
      @(posedge clk);
      #1;
      if (took) check_result(got);
      res_ready = next_ready;
    end
  end

  initial begin : run
    rst       = 1'b1;
    req       = '0;
    req_valid = 1'b0;
    repeat (5) @(posedge clk);
    #1;
    rst = 1'b0;
    for (int v = 0; v < 4; v++) begin
      for (int i = 0; i < 6; i++) begin
        send({variant_name[v], "_corner"}, rv32m_pkg::mul_funct3_t'(3'(v)),
             corner_a[i], corner_b[i]);
      end
    end
    for (int i = 0; i < 60; i++) send_random("random");
    drain();
    stall_test();
    drain();
    assert (received == sent) else begin
      errors++;
      $display("FAIL result_count: expected %0d, actual %0d", sent, received);
    end
    $display("closing: %0d check errors, %0d assertion failures, %0d sent, %0d received",
             errors, UUT.sva.fail_count, sent, received);
    if (errors == 0 && UUT.sva.fail_count == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule : tb_muldiv

/* hdl/mul_issue.sv */
module mul_issue (
    input logic clk,
    input logic rst,

    input  muldiv_pkg::mul_req_t req,
    input  logic                 req_valid,
    output logic                 req_ready,

    output muldiv_pkg::mul_op_t op,
    output logic                op_valid,
    input  logic                op_ready
);

  logic                sign_a;  // rs1 treated as signed
  logic                sign_b;  // rs2 treated as signed
  muldiv_pkg::mul_op_t op_next;

  // slot is free, or its content leaves on this edge
  assign req_ready = !op_valid || op_ready;

  // signedness per variant
  always_comb begin
    sign_a = 1'b1;
    sign_b = 1'b1;
    case (req.funct3)
      rv32m_pkg::funct3_mulhsu: begin
        sign_b = 1'b0;
      end
      rv32m_pkg::funct3_mulhu: begin
        sign_a = 1'b0;
        sign_b = 1'b0;
      end
      default: ;  // mul and mulh sign-extend both
    endcase
  end

  always_comb begin
    op_next.tag    = req.tag;
    op_next.rd     = req.rd;
    op_next.hi_sel = (req.funct3 != rv32m_pkg::funct3_mul);
    op_next.a      = {sign_a & req.rs1[rv32m_pkg::xlen-1], req.rs1};
    op_next.b      = {sign_b & req.rs2[rv32m_pkg::xlen-1], req.rs2};
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      op_valid <= 1'b0;
    end else if (req_ready) begin
      op_valid <= req_valid;
    end
  end

  // payload register loaded only on a transfer
  always_ff @(posedge clk) begin
    if (req_valid && req_ready) begin
      op <= op_next;
    end
  end

endmodule : mul_issue

/* hdl/muldiv_pkg.sv */
package muldiv_pkg;

  // reorder tag carried through the unit
  localparam int tag_width = 4;

  typedef logic [tag_width-1:0] tag_t;

  // operand after sign or zero extension to xlen+1 bits
  typedef logic [rv32m_pkg::xlen:0] ext_word_t;

  // request as it arrives from the issue side
  typedef struct packed {
    tag_t                   tag;
    rv32m_pkg::reg_addr_t   rd;
    rv32m_pkg::mul_funct3_t funct3;
    logic [rv32m_pkg::xlen-1:0] rs1;
    logic [rv32m_pkg::xlen-1:0] rs2;
  } mul_req_t;

  // prepared operation for the multiplier
  typedef struct packed {
    tag_t                 tag;
    rv32m_pkg::reg_addr_t rd;
    logic                 hi_sel;  // upper product word wanted
    ext_word_t            a;
    ext_word_t            b;
  } mul_op_t;

  // completion packet toward the CDB side
  typedef struct packed {
    tag_t                       tag;
    rv32m_pkg::reg_addr_t       rd;
    logic [rv32m_pkg::xlen-1:0] value;
  } mul_result_t;

endpackage : muldiv_pkg

/* hdl/muldiv_unit.sv */
module muldiv_unit #(
    parameter int op_depth  = 4,
    parameter int res_depth = 2
) (
    input logic clk,
    input logic rst,

    input  muldiv_pkg::mul_req_t req,
    input  logic                 req_valid,
    output logic                 req_ready,

    output muldiv_pkg::mul_result_t res,
    output logic                    res_valid,
    input  logic                    res_ready
);

  // issue -> operand queue
  muldiv_pkg::mul_op_t issue_op;
  logic                issue_valid;
  logic                issue_ready;

  // operand queue -> multiplier
  muldiv_pkg::mul_op_t mul_op;
  logic                mul_op_valid;
  logic                mul_op_ready;

  // multiplier -> result queue
  muldiv_pkg::mul_result_t mul_res;
  logic                    mul_res_valid;
  logic                    mul_res_ready;

  mul_issue issue (
      .clk      (clk),
      .rst      (rst),
      .req      (req),
      .req_valid(req_valid),
      .req_ready(req_ready),
      .op       (issue_op),
      .op_valid (issue_valid),
      .op_ready (issue_ready)
  );

  op_fifo #(
      .depth    (op_depth),
      .payload_t(muldiv_pkg::mul_op_t)
  ) op_queue (
      .clk      (clk),
      .rst      (rst),
      .in_data  (issue_op),
      .in_valid (issue_valid),
      .in_ready (issue_ready),
      .out_data (mul_op),
      .out_valid(mul_op_valid),
      .out_ready(mul_op_ready)
  );

  seq_multiplier mult (
      .clk      (clk),
      .rst      (rst),
      .op       (mul_op),
      .op_valid (mul_op_valid),
      .op_ready (mul_op_ready),
      .res      (mul_res),
      .res_valid(mul_res_valid),
      .res_ready(mul_res_ready)
  );

  op_fifo #(
      .depth    (res_depth),
      .payload_t(muldiv_pkg::mul_result_t)
  ) res_queue (
      .clk      (clk),
      .rst      (rst),
      .in_data  (mul_res),
      .in_valid (mul_res_valid),
      .in_ready (mul_res_ready),
      .out_data (res),
      .out_valid(res_valid),
      .out_ready(res_ready)
  );

endmodule : muldiv_unit

/* hdl/op_fifo.sv */
module op_fifo #(
    parameter int  depth     = 4,
    parameter type payload_t = logic [31:0]
) (
    input logic clk,
    input logic rst,

    input  payload_t in_data,
    input  logic     in_valid,
    output logic     in_ready,

    output payload_t out_data,
    output logic     out_valid,
    input  logic     out_ready
);

  localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;
  localparam int cnt_w = $clog2(depth + 1);

  payload_t           mem[depth];
  logic [ptr_w-1:0]   rd_ptr;
  logic [ptr_w-1:0]   wr_ptr;
  logic [cnt_w-1:0]   count;
  logic               push;
  logic               pop;

  assign in_ready  = (count != cnt_w'(depth));
  assign out_valid = (count != '0);
  assign out_data  = mem[rd_ptr];

  assign push = in_valid && in_ready;
  assign pop  = out_valid && out_ready;

  always_ff @(posedge clk) begin
    if (rst) begin
      rd_ptr <= '0;
      wr_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == ptr_w'(depth - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == ptr_w'(depth - 1)) ? '0 : rd_ptr + 1'b1;
      end
      // count moves only when exactly one side transfers
      if (push && !pop) begin
        count <= count + 1'b1;
      end else if (pop && !push) begin
        count <= count - 1'b1;
      end
    end
  end

  // storage
  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= in_data;
    end
  end

endmodule : op_fifo

/* hdl/rv32m_pkg.sv */
package rv32m_pkg;

  // architectural data word
  localparam int xlen = 32;

  // funct3 field of the OP opcode with funct7 = 0000001
  typedef enum logic [2:0] {
    funct3_mul    = 3'b000,  // low word of signed x signed
    funct3_mulh   = 3'b001,  // high word of signed x signed
    funct3_mulhsu = 3'b010,  // high word of signed x unsigned
    funct3_mulhu  = 3'b011   // high word of unsigned x unsigned
  } mul_funct3_t;

  // x0..x31
  typedef logic [4:0] reg_addr_t;

endpackage : rv32m_pkg

/* hdl/seq_multiplier.sv */
module seq_multiplier (
    input logic clk,
    input logic rst,

    input  muldiv_pkg::mul_op_t op,
    input  logic                op_valid,
    output logic                op_ready,

    output muldiv_pkg::mul_result_t res,
    output logic                    res_valid,
    input  logic                    res_ready
);

  localparam int op_w     = rv32m_pkg::xlen + 1;  // extended operand width
  localparam int acc_w    = 2 * op_w;
  localparam int last_bit = op_w - 1;

  typedef enum logic [1:0] {
    s_idle,
    s_busy,
    s_fin,
    s_done
  } state_t;

  state_t            state;
  logic [acc_w-1:0]  acc;
  logic [acc_w-1:0]  mcand;    // a shifted left every step
  logic [op_w-1:0]   mplier;   // b shifted right every step
  logic [5:0]        cnt;
  logic              hi_sel;
  logic [acc_w-1:0]  partial;

  assign op_ready  = (state == s_idle);
  assign res_valid = (state == s_done);

  assign partial = mplier[0] ? mcand : '0;

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= s_idle;
    end else begin
      case (state)
        s_idle: begin
          if (op_valid) begin
            state <= s_busy;
          end
        end
        s_busy: begin
          if (cnt == 6'(last_bit)) begin
            state <= s_fin;
          end
        end
        s_fin: begin
          state <= s_done;
        end
        s_done: begin
          if (res_ready) begin
            state <= s_idle;
          end
        end
        default: state <= s_idle;
      endcase
    end
  end

  // datapath
  always_ff @(posedge clk) begin
    case (state)
      s_idle: begin
        if (op_valid) begin
          acc     <= '0;
          mcand   <= {{op_w{op.a[op_w-1]}}, op.a};
          mplier  <= op.b;
          cnt     <= '0;
          hi_sel  <= op.hi_sel;
          res.tag <= op.tag;
          res.rd  <= op.rd;
        end
      end
      s_busy: begin
        // top bit of b has negative weight
        if (cnt == 6'(last_bit)) begin
          acc <= acc - partial;
        end else begin
          acc <= acc + partial;
        end
        mcand  <= mcand << 1;
        mplier <= mplier >> 1;
        cnt    <= cnt + 1'b1;
      end
      s_fin: begin
        res.value <= hi_sel ? acc[2*rv32m_pkg::xlen-1:rv32m_pkg::xlen]
                            : acc[rv32m_pkg::xlen-1:0];
      end
      default: ;  // hold result until taken
    endcase
  end

endmodule : seq_multiplier

/* muldiv.f */
hdl/rv32m_pkg.sv
hdl/muldiv_pkg.sv
hdl/mul_issue.sv
hdl/op_fifo.sv
hdl/seq_multiplier.sv
hdl/muldiv_unit.sv
bench/muldiv_sva.sv
bench/tb_muldiv.sv
